// File: project.f
+incdir+hw
hw/pgwr_pkg.sv
hw/pgwr_ctrl_fsm.sv
hw/pgwr_resp_tracker.sv
hw/pgwr_beat_builder.sv
hw/pgwr_list_regs.sv
hw/pgwr_top.sv
bench/tb_pgwr.sv

// File: run.sh
#!/bin/sh
# builds the page-table write manager testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tb_pgwr --Mdir obj_dir

./obj_dir/Vtb_pgwr > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
exit 0

// File: bench/tb_pgwr.sv
// testbench of the page-table write manager, needs assertions enabled
// memory model covers 32 lines from the att base, list table included
// the bus error test leaves the last update open, so it runs last
`timescale 1ns/100ps
`include "pgwr_settings.svh"

module tb_pgwr;

	localparam int ATT_N      = `PGWR_ATT_ENTRIES;
	localparam int LIST_N     = `PGWR_LIST_ENTRIES;
	localparam int STALL_MAX  = 7;                               // 3 random bits per stall
	localparam int TEST_BEATS = ATT_N + LIST_N + 4 * (LIST_N + 1);
	localparam int TIMEOUT_CYCLES = TEST_BEATS * (3 + 3 * STALL_MAX) + 200;
	localparam int MEM_LINES  = 32;

	logic clk_i     = 1'b0;
	logic rst_ni    = 1'b0;
	logic init_att  = 1'b0;
	logic init_list = 1'b0;
	pgwr_pkg::upd_pkt_t upd     = '0;
	pgwr_pkg::wr_rdy_t  wr_rdy  = '1;
	pgwr_pkg::wr_resp_t wr_resp = '0;
	pgwr_pkg::wr_req_t  wr_req;
	pgwr_pkg::list_ht_t list_ht;
	logic ready, upd_done, init_att_done, init_list_done, bus_error;
	logic aw_fire, w_fire;

	// bus side model
	pgwr_pkg::line_data_t mem [MEM_LINES];
	pgwr_pkg::axi_addr_t  aw_addr_q;
	logic [2:0]  aw_wait, w_wait, b_wait;
	logic [1:0]  resp_q [$];                                     // pending bresp, in order
	logic [31:0] bus_lfsr;
	logic        err_armed = 1'b0;
	logic        err_sent;
	int          err_rsps  = 0;                                  // B beats since the error arm

	// reference copy of both tables
	pgwr_pkg::lst_ptr_t   ref_prev [1:LIST_N];
	pgwr_pkg::lst_ptr_t   ref_next [1:LIST_N];
	pgwr_pkg::lst_ptr_t   ref_lat  [1:LIST_N];
	pgwr_pkg::att_entry_t ref_att  [1:ATT_N];
	pgwr_pkg::lst_ptr_t   ref_fh, ref_ft, ref_uh, ref_ut;
	logic [31:0]          pkt_lfsr;

	int val_errs   = 0;
	int proto_errs = 0;
	int cycles     = 0;

	pgwr_top i_dut (
		.clk_i, .rst_ni, .init_att, .init_list, .upd, .wr_rdy, .wr_resp,
		.wr_req, .list_ht, .ready, .upd_done, .init_att_done, .init_list_done, .bus_error
	);

	assign aw_fire = wr_req.awvalid & wr_rdy.awready;
	assign w_fire  = wr_req.wvalid & wr_rdy.wready;

	always #10 clk_i = ~clk_i;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};             // taps 32 22 2 1
	endfunction

	task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			st = lfsr_step(st);
			v  = {v[30:0], st[0]};    // one step per bit
		end
	endtask

	function automatic logic [7:0] fill_byte(input pgwr_pkg::axi_addr_t a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32] ^ a[47:40] ^
			a[55:48] ^ a[63:56] ^ 8'ha5;
	endfunction

	task automatic check_val(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp) else begin
			val_errs++;
			$display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic protocol_fail(input string what);
		proto_errs++;
		$display("at %0t: %s", $time, what);
	endtask

	// slot rule, 8 att entries of 8 bytes per line
	function automatic pgwr_pkg::att_entry_t att_at(input int n);
		pgwr_pkg::axi_addr_t a;
		a = `PGWR_ATT_BASE + 64'((n - 1) / 8) * 64;
		return mem[int'((a - `PGWR_ATT_BASE) >> 6)][((n - 1) % 8) * 64 +: 64];
	endfunction

	// 4 list entries of 16 bytes per line
	function automatic pgwr_pkg::lst_entry_t lst_at(input int n);
		pgwr_pkg::axi_addr_t a;
		a = `PGWR_LIST_BASE + 64'((n - 1) / 4) * 64;
		return mem[int'((a - `PGWR_ATT_BASE) >> 6)][((n - 1) % 4) * 128 +: 128];
	endfunction

	task automatic check_tables();
		pgwr_pkg::lst_entry_t e;
		int n;
		for (n = 1; n <= ATT_N; n++)
			check_val($sformatf("att[%0d]", n), att_at(n), ref_att[n]);
		for (n = 1; n <= LIST_N; n++) begin
			e        = '0;           // rsvd stays zero after list init
			e.way    = pgwr_pkg::way_t'(`PGWR_PPA_PAGE0) + pgwr_pkg::way_t'(n - 1);
			e.att_id = ref_lat[n];
			e.prev   = ref_prev[n];
			e.next   = ref_next[n];
			check_val($sformatf("list[%0d]", n), lst_at(n), e);
		end
		check_val("free_head", list_ht.free_head, ref_fh);
		check_val("free_tail", list_ht.free_tail, ref_ft);
		check_val("unc_head", list_ht.unc_head, ref_uh);
		check_val("unc_tail", list_ht.unc_tail, ref_ut);
	endtask

	// reference move of one entry, free head to uncompressed tail
	task automatic apply_ref(input pgwr_pkg::upd_pkt_t p);
		pgwr_pkg::lst_ptr_t nxt;
		int t;
		t = int'(p.tol_id);
		ref_att[int'(p.att_id)].sts     = pgwr_pkg::UNCOMP;
		ref_att[int'(p.att_id)].way     = p.entry.way;
		ref_att[int'(p.att_id)].zpd_cnt = p.zpd_cnt;
		if (ref_fh != ref_ft) begin
			nxt = ref_next[t];
			ref_prev[int'(nxt)] = '0;
			ref_fh = nxt;
		end else begin               // last free entry gone
			ref_fh = '0;
			ref_ft = '0;
		end
		ref_prev[t] = ref_ut;
		ref_next[t] = '0;
		ref_lat[t]  = pgwr_pkg::lst_ptr_t'(p.att_id);
		if (ref_ut != '0) begin
			ref_next[int'(ref_ut)] = p.tol_id;
			ref_ut = p.tol_id;
		end else begin
			ref_uh = p.tol_id;
			ref_ut = p.tol_id;
		end
	endtask

	task automatic build_pkt(input pgwr_pkg::lst_ptr_t tol, output pgwr_pkg::upd_pkt_t p);
		logic [31:0] r;
		p = '0;
		p.valid  = 1'b1;
		p.tol_id = tol;
		p.entry  = lst_at(int'(tol));     // contents as the model holds them
		draw_bits(pkt_lfsr, 4, r);
		p.att_id = pgwr_pkg::att_id_t'({1'b0, r[3:0]} + 5'd1);
		draw_bits(pkt_lfsr, 22, r);
		p.zpd_cnt = pgwr_pkg::zpd_cnt_t'(r);
	endtask

	task automatic send_update(input pgwr_pkg::upd_pkt_t p);
		@(posedge clk_i);
		upd <= p;
		@(negedge clk_i);
		check_val("ready", ready, 1'b1);  // taken at the coming edge
		@(posedge clk_i);
		upd.valid <= 1'b0;
	endtask

	// slave side: random ready stalls, strobe merge, in-order B
	always @(posedge clk_i) begin
		pgwr_pkg::line_data_t line;
		pgwr_pkg::axi_addr_t  off;
		logic [31:0] r;
		int i;
		int b;
		if (!rst_ni) begin
			for (i = 0; i < MEM_LINES; i++) begin
				for (b = 0; b < 64; b++)
					line[b * 8 +: 8] = fill_byte(`PGWR_ATT_BASE + 64'(i * 64 + b));
				mem[i] <= line;
			end
			bus_lfsr = 32'hb36e;
			aw_wait  <= '0;
			w_wait   <= '0;
			b_wait   <= '0;
			err_sent <= 1'b0;
			resp_q.delete();
			wr_rdy   <= '1;
			wr_resp  <= '0;
		end else begin
			if (aw_fire) begin
				aw_addr_q <= wr_req.addr;
				draw_bits(bus_lfsr, 3, r);
				aw_wait <= r[2:0];
				wr_rdy.awready <= r[2:0] == 3'd0;
			end else if (aw_wait != 3'd0) begin
				aw_wait <= aw_wait - 3'd1;
				wr_rdy.awready <= aw_wait == 3'd1;
			end
			if (w_fire) begin
				draw_bits(bus_lfsr, 3, r);
				w_wait <= r[2:0];
				wr_rdy.wready <= r[2:0] == 3'd0;
				off = aw_addr_q - `PGWR_ATT_BASE;   // wraps huge when below the base
				if (aw_addr_q[5:0] != 6'd0 || off >= 64'(MEM_LINES * 64)) begin
					protocol_fail($sformatf("write to %0h lies outside both tables",
						aw_addr_q));
				end else begin
					line = mem[int'(off >> 6)];
					for (b = 0; b < 64; b++)
						if (wr_req.strb[b])
							line[b * 8 +: 8] = wr_req.data[b * 8 +: 8];
					mem[int'(off >> 6)] <= line;
				end
				resp_q.push_back((err_armed && !err_sent) ? 2'b10 : 2'b00);
				if (err_armed)
					err_sent <= 1'b1;             // one slave error only
			end else if (w_wait != 3'd0) begin
				w_wait <= w_wait - 3'd1;
				wr_rdy.wready <= w_wait == 3'd1;
			end
			wr_resp.bvalid <= 1'b0;
			if (b_wait != 3'd0) begin
				b_wait <= b_wait - 3'd1;
			end else if (resp_q.size() != 0) begin
				wr_resp.bvalid <= 1'b1;
				wr_resp.bresp  <= resp_q.pop_front();
				if (err_armed)
					err_rsps <= err_rsps + 1;
				draw_bits(bus_lfsr, 3, r);
				b_wait <= r[2:0];             // gap before the next response
			end
		end
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the DUT did not finish within %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	a_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wr_req.awvalid && !wr_rdy.awready |=> wr_req.awvalid && $stable(wr_req.addr))
		else protocol_fail("AW request changed or fell while awready was low");

	a_w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wr_req.wvalid && !wr_rdy.wready |=>
		wr_req.wvalid && $stable(wr_req.data) && $stable(wr_req.strb))
		else protocol_fail("W beat changed or fell while wready was low");

	a_w_after_aw: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$rose(wr_req.wvalid) |-> $past(aw_fire))
		else protocol_fail("wvalid rose without an AW handshake the cycle before");

	a_one_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(wr_req.awvalid && wr_req.wvalid))
		else protocol_fail("AW and W requested at once, more than one write in flight");

	a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
		ready |-> !wr_req.awvalid && !wr_req.wvalid)
		else protocol_fail("bus request while the DUT reports ready");

	a_upd_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
		upd_done |=> !upd_done && ready)
		else protocol_fail("upd_done longer than one cycle or ready not back after it");

	a_init_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$rose(init_att_done) || $rose(init_list_done) |=> ready)
		else protocol_fail("ready not back in the cycle after an init done flag");

	a_err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_error |=> bus_error)
		else protocol_fail("bus_error cleared without a reset");

	initial begin
		pgwr_pkg::upd_pkt_t pkt;
		int k;
		pkt_lfsr = 32'hb36e;
		repeat (5) @(posedge clk_i);
		rst_ni <= 1'b1;

		// state after reset
		@(negedge clk_i);
		check_val("awvalid", wr_req.awvalid, 1'b0);
		check_val("wvalid", wr_req.wvalid, 1'b0);
		check_val("upd_done", upd_done, 1'b0);
		check_val("init_att_done", init_att_done, 1'b0);
		check_val("init_list_done", init_list_done, 1'b0);
		check_val("bus_error", bus_error, 1'b0);
		check_val("ready", ready, 1'b1);
		check_val("list_ht", list_ht, '0);

		// att init, every entry deallocated
		@(posedge clk_i);
		init_att <= 1'b1;
		do @(negedge clk_i); while (!init_att_done);
		for (k = 1; k <= ATT_N; k++)
			ref_att[k] = '0;
		for (k = 1; k <= ATT_N; k++)
			check_val($sformatf("att[%0d]", k), att_at(k), ref_att[k]);

		// list init, one free list 1..N
		@(posedge clk_i);
		init_att  <= 1'b0;
		init_list <= 1'b1;
		do @(negedge clk_i); while (!init_list_done);
		for (k = 1; k <= LIST_N; k++) begin
			ref_prev[k] = pgwr_pkg::lst_ptr_t'(k - 1);
			ref_next[k] = (k == LIST_N) ? '0 : pgwr_pkg::lst_ptr_t'(k + 1);
			ref_lat[k]  = '0;
		end
		ref_fh = pgwr_pkg::lst_ptr_t'(1);
		ref_ft = pgwr_pkg::lst_ptr_t'(LIST_N);
		ref_uh = '0;
		ref_ut = '0;
		check_tables();
		@(posedge clk_i);
		init_list <= 1'b0;

		// move every free entry to the uncompressed list
		for (k = 1; k <= LIST_N; k++) begin
			build_pkt(ref_fh, pkt);
			send_update(pkt);
			apply_ref(pkt);
			do @(negedge clk_i); while (!upd_done);
			check_tables();
		end
		check_val("bus_error", bus_error, 1'b0);

		// slave error on the first write of one more update
		err_armed = 1'b1;
		build_pkt(ref_uh, pkt);
		send_update(pkt);
		// free list empty and uncompressed list not, so att, self and link writes
		do @(negedge clk_i); while (err_rsps != 3);
		repeat (2) @(negedge clk_i);          // ready would be back by now
		check_val("bus_error", bus_error, 1'b1);
		check_val("ready", ready, 1'b0);      // error response never completes the op

		$display("checks finished: %0d value errors, %0d protocol errors",
			val_errs, proto_errs);
		if (val_errs + proto_errs == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: hw/pgwr_top.sv
// page-table write manager, bready is assumed always high
// one write in flight at a time, responses must come back in order
`timescale 1ns/100ps

module pgwr_top (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 init_att,
	input  logic                 init_list,
	input  pgwr_pkg::upd_pkt_t   upd,
	input  pgwr_pkg::wr_rdy_t    wr_rdy,
	input  pgwr_pkg::wr_resp_t   wr_resp,
	output pgwr_pkg::wr_req_t    wr_req,
	output pgwr_pkg::list_ht_t   list_ht,
	output logic                 ready,
	output logic                 upd_done,
	output logic                 init_att_done,
	output logic                 init_list_done,
	output logic                 bus_error
);

	logic awvalid, wvalid, load, aw_fire;
	logic pop_free, free_to_null, push_unc, set_unc_first, init_free, trk_clear;
	logic free_single, unc_empty, resp_done;
	pgwr_pkg::beat_op_e   op;
	pgwr_pkg::att_id_t    entry_cnt;
	pgwr_pkg::upd_pkt_t   upd_q;
	pgwr_pkg::axi_addr_t  addr;
	pgwr_pkg::line_data_t data;
	pgwr_pkg::line_strb_t strb;

	assign aw_fire = awvalid & wr_rdy.awready;

	assign wr_req.awvalid = awvalid;
	assign wr_req.addr    = addr;
	assign wr_req.wvalid  = wvalid;
	assign wr_req.data    = data;
	assign wr_req.strb    = strb;

	pgwr_ctrl_fsm i_ctrl_fsm (
		.clk_i, .rst_ni, .init_att, .init_list, .upd, .wr_rdy,
		.free_single, .unc_empty, .resp_done,
		.awvalid, .wvalid, .load, .op, .entry_cnt,
		.pop_free, .free_to_null, .push_unc, .set_unc_first, .init_free, .trk_clear,
		.ready, .upd_done, .init_att_done, .init_list_done, .upd_q
	);

	pgwr_resp_tracker i_resp_tracker (
		.clk_i, .rst_ni, .trk_clear, .aw_fire, .wr_resp, .resp_done, .bus_error
	);

	pgwr_beat_builder i_beat_builder (
		.clk_i, .rst_ni, .load, .op, .entry_cnt, .upd_q, .list_ht,
		.addr, .data, .strb
	);

	pgwr_list_regs i_list_regs (
		.clk_i, .rst_ni, .init_free, .pop_free, .free_to_null, .push_unc, .set_unc_first,
		.new_head(upd_q.entry.next),   // successor of the popped free head
		.tol_id(upd_q.tol_id),
		.list_ht, .free_single, .unc_empty
	);

endmodule

// File: hw/pgwr_list_regs.sv
// head and tail pointers of the free and uncompressed lists
// all pointers are null after reset, commands are one-cycle strobes
`timescale 1ns/100ps
`include "pgwr_settings.svh"

module pgwr_list_regs (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  logic                init_free,
	input  logic                pop_free,
	input  logic                free_to_null,
	input  logic                push_unc,
	input  logic                set_unc_first,
	input  pgwr_pkg::lst_ptr_t  new_head,
	input  pgwr_pkg::lst_ptr_t  tol_id,
	output pgwr_pkg::list_ht_t  list_ht,
	output logic                free_single,
	output logic                unc_empty
);

	pgwr_pkg::list_ht_t ht_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			ht_q <= '0;
		end else if (init_free) begin
			ht_q.free_head <= pgwr_pkg::lst_ptr_t'(1);
			ht_q.free_tail <= pgwr_pkg::lst_ptr_t'(`PGWR_LIST_ENTRIES);
			ht_q.unc_head  <= '0;    // fresh table, nothing uncompressed
			ht_q.unc_tail  <= '0;
		end else begin
			if (pop_free)
				ht_q.free_head <= new_head;
			if (free_to_null) begin  // last free entry taken
				ht_q.free_head <= '0;
				ht_q.free_tail <= '0;
			end
			if (set_unc_first) begin
				ht_q.unc_head <= tol_id;
				ht_q.unc_tail <= tol_id;
			end
			if (push_unc)
				ht_q.unc_tail <= tol_id;
		end
	end

	assign list_ht = ht_q;
	// one entry left, or none
	assign free_single = ht_q.free_head == ht_q.free_tail;
	assign unc_empty   = ht_q.unc_tail == '0;

	a_ht_null: assert property (@(posedge clk_i) disable iff (!rst_ni)
		((ht_q.free_head == '0) == (ht_q.free_tail == '0)) &&
		((ht_q.unc_head == '0) == (ht_q.unc_tail == '0)));

endmodule

// File: hw/pgwr_beat_builder.sv
// forms address, data and byte strobes of one table write
// payload is taken on load and held until the next load
// ids arrive 1-based; id 0 would wrap to the last slot
`timescale 1ns/100ps
`include "pgwr_settings.svh"

module pgwr_beat_builder (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  load,
	input  pgwr_pkg::beat_op_e    op,
	input  pgwr_pkg::att_id_t     entry_cnt,
	input  pgwr_pkg::upd_pkt_t    upd_q,
	input  pgwr_pkg::list_ht_t    list_ht,
	output pgwr_pkg::axi_addr_t   addr,
	output pgwr_pkg::line_data_t  data,
	output pgwr_pkg::line_strb_t  strb
);

	pgwr_pkg::att_id_t    att_sel, att_m1;
	pgwr_pkg::lst_ptr_t   lst_sel, lst_m1;
	pgwr_pkg::att_entry_t att_e;
	pgwr_pkg::lst_entry_t lst_e;
	logic [15:0]          lst_mask;      // byte enables inside one list entry
	logic                 is_att;
	pgwr_pkg::axi_addr_t  addr_n;
	pgwr_pkg::line_data_t data_n;
	pgwr_pkg::line_strb_t strb_n;

	assign is_att  = (op == pgwr_pkg::ATT_INIT) || (op == pgwr_pkg::ATT_SET);
	assign att_sel = (op == pgwr_pkg::ATT_SET) ? upd_q.att_id : entry_cnt;

	// which list entry this beat touches
	always_comb begin
		case (op)
			pgwr_pkg::POP_FREE:  lst_sel = upd_q.entry.next;   // new free head
			pgwr_pkg::PUSH_SELF: lst_sel = upd_q.tol_id;
			pgwr_pkg::LINK_TAIL: lst_sel = list_ht.unc_tail;   // old tail, not yet moved
			default:             lst_sel = pgwr_pkg::lst_ptr_t'(entry_cnt);
		endcase
	end

	assign att_m1 = att_sel - 1'b1;
	assign lst_m1 = lst_sel - 1'b1;

	// entry contents
	always_comb begin
		att_e    = '0;            // DALLOC, way 0, zpd 0
		lst_e    = '0;
		lst_mask = 16'h0000;
		case (op)
			pgwr_pkg::ATT_SET: begin
				att_e.sts     = pgwr_pkg::UNCOMP;
				att_e.way     = upd_q.entry.way;
				att_e.zpd_cnt = upd_q.zpd_cnt;
			end
			pgwr_pkg::LIST_INIT: begin
				lst_e.way  = pgwr_pkg::way_t'(`PGWR_PPA_PAGE0) +
					pgwr_pkg::way_t'(entry_cnt) - 1'b1;
				lst_e.prev = pgwr_pkg::lst_ptr_t'(entry_cnt) - 1'b1;   // entry 1 gets null
				if (entry_cnt == pgwr_pkg::att_id_t'(`PGWR_LIST_ENTRIES))
					lst_e.next = '0;
				else
					lst_e.next = pgwr_pkg::lst_ptr_t'(entry_cnt) + 1'b1;
				lst_mask = 16'hffff;  // full entry
			end
			pgwr_pkg::POP_FREE: lst_mask = 16'h0038;   // prev only, left null
			pgwr_pkg::PUSH_SELF: begin
				lst_e.prev   = list_ht.unc_tail;
				lst_e.att_id = pgwr_pkg::lst_ptr_t'(upd_q.att_id);
				lst_mask     = 16'h01ff;   // next, prev, att id
			end
			pgwr_pkg::LINK_TAIL: begin
				lst_e.next = upd_q.tol_id;
				lst_mask   = 16'h0007;     // next only
			end
			default: ;
		endcase
	end

	// slot placement, 8 att or 4 list entries per line
	always_comb begin
		data_n = '0;
		strb_n = '0;
		if (is_att) begin
			addr_n = `PGWR_ATT_BASE + (pgwr_pkg::axi_addr_t'(att_m1 >> 3) << 6);
			data_n[att_m1[2:0]*64 +: 64] = att_e;
			strb_n[att_m1[2:0]*8 +: 8]   = 8'hff;
		end else begin
			addr_n = `PGWR_LIST_BASE + (pgwr_pkg::axi_addr_t'(lst_m1 >> 2) << 6);
			data_n[lst_m1[1:0]*128 +: 128] = lst_e;
			strb_n[lst_m1[1:0]*16 +: 16]   = lst_mask;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni)
			strb <= '0;           // no bytes enabled before the first beat
		else if (load)
			strb <= strb_n;
	end

	always_ff @(posedge clk_i) begin
		if (load) begin
			addr <= addr_n;
			data <= data_n;
		end
	end

endmodule

// File: hw/pgwr_resp_tracker.sv
// counts accepted addresses against good responses, in-order B only
// at most 127 writes per operation; bus_error stays set until reset
`timescale 1ns/100ps

module pgwr_resp_tracker (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  logic                trk_clear,
	input  logic                aw_fire,
	input  pgwr_pkg::wr_resp_t  wr_resp,
	output logic                resp_done,
	output logic                bus_error
);

	logic [6:0] req_cnt;
	logic [6:0] rsp_cnt;
	logic       rsp_ok;
	logic       rsp_bad;

	assign rsp_ok  = wr_resp.bvalid & (wr_resp.bresp == 2'b00);
	assign rsp_bad = wr_resp.bvalid & (wr_resp.bresp != 2'b00);   // not counted as complete

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			req_cnt   <= '0;
			rsp_cnt   <= '0;
			bus_error <= 1'b0;
		end else begin
			if (trk_clear) begin   // new operation
				req_cnt <= '0;
				rsp_cnt <= '0;
			end else begin
				if (aw_fire)
					req_cnt <= req_cnt + 1'b1;
				if (rsp_ok)
					rsp_cnt <= rsp_cnt + 1'b1;
			end
			if (rsp_bad)
				bus_error <= 1'b1;
		end
	end

	assign resp_done = (req_cnt == rsp_cnt) && (req_cnt != '0);

	// a response never shows up for an address that was not sent
	a_rsp_le_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rsp_cnt <= req_cnt);

endmodule

// File: hw/pgwr_ctrl_fsm.sv
// sequences the table write beats, one AW and one W beat per write
// a new request is taken only in idle; init_att wins over init_list over upd
// list register commands are single-cycle, issued on the W handshake
`timescale 1ns/100ps
`include "pgwr_settings.svh"

module pgwr_ctrl_fsm (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  init_att,
	input  logic                  init_list,
	input  pgwr_pkg::upd_pkt_t    upd,
	input  pgwr_pkg::wr_rdy_t     wr_rdy,
	input  logic                  free_single,
	input  logic                  unc_empty,
	input  logic                  resp_done,
	output logic                  awvalid,
	output logic                  wvalid,
	output logic                  load,
	output pgwr_pkg::beat_op_e    op,
	output pgwr_pkg::att_id_t     entry_cnt,
	output logic                  pop_free,
	output logic                  free_to_null,
	output logic                  push_unc,
	output logic                  set_unc_first,
	output logic                  init_free,
	output logic                  trk_clear,
	output logic                  ready,
	output logic                  upd_done,
	output logic                  init_att_done,
	output logic                  init_list_done,
	output pgwr_pkg::upd_pkt_t    upd_q
);

	pgwr_pkg::pgwr_state_e state_q, state_n;
	pgwr_pkg::beat_op_e    op_n;
	pgwr_pkg::att_id_t     cnt_n;
	logic start_att, start_list, start_upd;
	logic aw_fire, w_fire;
	logic fin;                         // last response of the operation is in
	logic att_done_q, list_done_q;

	assign aw_fire = awvalid & wr_rdy.awready;
	assign w_fire  = wvalid & wr_rdy.wready;
	assign ready   = state_q == pgwr_pkg::PG_IDLE;
	assign load    = state_q == pgwr_pkg::PG_LOAD;

	// request priority
	assign start_att  = ready & init_att & ~att_done_q;
	assign start_list = ready & ~start_att & init_list & ~list_done_q;
	assign start_upd  = ready & ~start_att & ~start_list & upd.valid;
	assign trk_clear  = start_att | start_list | start_upd;

	assign fin = (state_q == pgwr_pkg::PG_RESP) & resp_done;
	// op still holds the last beat, so it tells which operation ends
	assign upd_done = fin & (op != pgwr_pkg::ATT_INIT) & (op != pgwr_pkg::LIST_INIT);
	assign init_att_done  = att_done_q | (fin & (op == pgwr_pkg::ATT_INIT));
	assign init_list_done = list_done_q | (fin & (op == pgwr_pkg::LIST_INIT));

	always_comb begin
		state_n       = state_q;
		op_n          = op;
		cnt_n         = entry_cnt;
		pop_free      = 1'b0;
		free_to_null  = 1'b0;
		push_unc      = 1'b0;
		set_unc_first = 1'b0;
		init_free     = 1'b0;
		case (state_q)
			pgwr_pkg::PG_IDLE: begin
				if (start_att) begin
					op_n    = pgwr_pkg::ATT_INIT;
					cnt_n   = pgwr_pkg::att_id_t'(1);
					state_n = pgwr_pkg::PG_LOAD;
				end else if (start_list) begin
					op_n    = pgwr_pkg::LIST_INIT;
					cnt_n   = pgwr_pkg::att_id_t'(1);
					state_n = pgwr_pkg::PG_LOAD;
				end else if (start_upd) begin
					op_n    = pgwr_pkg::ATT_SET;     // att entry always goes first
					state_n = pgwr_pkg::PG_LOAD;
				end
			end
			pgwr_pkg::PG_LOAD: state_n = pgwr_pkg::PG_AW;
			pgwr_pkg::PG_AW: begin
				if (aw_fire)
					state_n = pgwr_pkg::PG_W;
			end
			pgwr_pkg::PG_W: begin
				if (w_fire) begin
					state_n = pgwr_pkg::PG_LOAD;  // next beat unless the op ends below
					case (op)
						pgwr_pkg::ATT_INIT: begin
							if (entry_cnt == pgwr_pkg::att_id_t'(`PGWR_ATT_ENTRIES))
								state_n = pgwr_pkg::PG_RESP;
							else
								cnt_n = entry_cnt + 1'b1;
						end
						pgwr_pkg::LIST_INIT: begin
							if (entry_cnt == pgwr_pkg::att_id_t'(`PGWR_LIST_ENTRIES)) begin
								init_free = 1'b1;         // whole table is one free list now
								state_n   = pgwr_pkg::PG_RESP;
							end else begin
								cnt_n = entry_cnt + 1'b1;
							end
						end
						pgwr_pkg::ATT_SET: begin
							free_to_null = free_single;   // last free entry, no pop write
							op_n = free_single ? pgwr_pkg::PUSH_SELF : pgwr_pkg::POP_FREE;
						end
						pgwr_pkg::POP_FREE: begin
							pop_free = 1'b1;
							op_n     = pgwr_pkg::PUSH_SELF;
						end
						pgwr_pkg::PUSH_SELF: begin
							if (unc_empty) begin
								set_unc_first = 1'b1;     // no old tail to link
								state_n       = pgwr_pkg::PG_RESP;
							end else begin
								op_n = pgwr_pkg::LINK_TAIL;
							end
						end
						default: begin                    // LINK_TAIL
							push_unc = 1'b1;
							state_n  = pgwr_pkg::PG_RESP;
						end
					endcase
				end
			end
			pgwr_pkg::PG_RESP: begin
				if (resp_done)
					state_n = pgwr_pkg::PG_IDLE;
			end
			default: state_n = pgwr_pkg::PG_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q     <= pgwr_pkg::PG_IDLE;
			op          <= pgwr_pkg::ATT_INIT;
			entry_cnt   <= '0;
			awvalid     <= 1'b0;
			wvalid      <= 1'b0;
			att_done_q  <= 1'b0;
			list_done_q <= 1'b0;
		end else begin
			state_q   <= state_n;
			op        <= op_n;
			entry_cnt <= cnt_n;
			if (load)                     // rises together with the builder address
				awvalid <= 1'b1;
			else if (aw_fire)
				awvalid <= 1'b0;
			if (aw_fire)                  // W beat one cycle after the AW handshake
				wvalid <= 1'b1;
			else if (w_fire)
				wvalid <= 1'b0;
			if (init_att_done)
				att_done_q <= 1'b1;       // sticky
			if (init_list_done)
				list_done_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_upd)
			upd_q <= upd;                 // held for the whole update
	end

	// AW request is withdrawn only after the slave took it
	a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		awvalid && !wr_rdy.awready |=> awvalid);

endmodule

// File: hw/pgwr_pkg.sv
// types shared by the write manager blocks and the testbench
// att entry is 64 bits, list entry 128 bits, a table line 64 bytes
// pointer 0 is null everywhere
`include "pgwr_settings.svh"

package pgwr_pkg;

	typedef logic [`PGWR_PTR_W-1:0] lst_ptr_t;                  // 0 = null
	typedef logic [$clog2(`PGWR_ATT_ENTRIES):0] att_id_t;       // extra bit so the top id fits
	typedef logic [`PGWR_WAY_W-1:0] way_t;
	typedef logic [61-`PGWR_WAY_W:0] zpd_cnt_t;                 // what is left of the att entry
	typedef logic [63:0] axi_addr_t;
	typedef logic [511:0] line_data_t;
	typedef logic [63:0] line_strb_t;

	typedef enum logic [1:0] {
		DALLOC = 2'd0,
		UNCOMP = 2'd1,
		COMP   = 2'd2,
		INCOMP = 2'd3
	} att_sts_e;

	typedef struct packed {
		zpd_cnt_t zpd_cnt;
		way_t     way;
		att_sts_e sts;      // low bits
	} att_entry_t;

	// next in bytes 0-2, prev in 3-5, att id in 6-8
	typedef struct packed {
		logic [127-3*`PGWR_PTR_W-`PGWR_WAY_W:0] rsvd;
		way_t     way;
		lst_ptr_t att_id;   // att id stored pointer-wide
		lst_ptr_t prev;
		lst_ptr_t next;
	} lst_entry_t;

	typedef struct packed {
		logic       valid;
		att_id_t    att_id;
		lst_ptr_t   tol_id;   // list entry being moved
		lst_entry_t entry;    // its current contents, next = free successor
		zpd_cnt_t   zpd_cnt;
	} upd_pkt_t;

	typedef struct packed {
		logic       awvalid;
		axi_addr_t  addr;
		logic       wvalid;
		line_data_t data;
		line_strb_t strb;
	} wr_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
	} wr_rdy_t;

	typedef struct packed {
		logic       bvalid;
		logic [1:0] bresp;
	} wr_resp_t;

	typedef struct packed {
		lst_ptr_t free_head;
		lst_ptr_t free_tail;
		lst_ptr_t unc_head;
		lst_ptr_t unc_tail;
	} list_ht_t;

	typedef enum logic [2:0] {
		ATT_INIT,
		LIST_INIT,
		ATT_SET,
		POP_FREE,
		PUSH_SELF,
		LINK_TAIL
	} beat_op_e;

	typedef enum logic [2:0] {
		PG_IDLE,
		PG_LOAD,    // builder registers the beat
		PG_AW,
		PG_W,
		PG_RESP
	} pgwr_state_e;

endpackage

// File: hw/pgwr_settings.svh
// table geometry and field widths of the page-table write manager
// list and att ids are 1-based, id 0 is the null pointer
// both tables must start on a 64-byte line boundary
`ifndef PGWR_SETTINGS_SVH
`define PGWR_SETTINGS_SVH

// entries per table
`define PGWR_ATT_ENTRIES 16
`define PGWR_LIST_ENTRIES 8

// byte addresses of the two tables
`define PGWR_ATT_BASE 64'h0000_0000_8000_0000
`define PGWR_LIST_BASE 64'h0000_0000_8000_0400

// page number handed to list entry 1, the rest count up from here
`define PGWR_PPA_PAGE0 40'h00_0008_0100

// list pointers, 3 bytes each in memory
`define PGWR_PTR_W 24

// page number field, shared by att and list entries
`define PGWR_WAY_W 40

`endif
